// File: spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Slaves on the shared bus, one select each
`define SPI_NUM_SLAVES 8

// Byte width, a frame is two bytes
`define SPI_DATA_W 8

// clk cycles per sclk half-period
`define SPI_CLK_DIV 4

// Register addresses per slave, the last one is the identity
`define SPI_NUM_REGS 4

`endif

// File: spi_pkg.sv
// Types shared by the SPI master, the register slaves and the testbench
package spi_pkg;

  // Opcode in bit 7 of the command byte
  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } spi_cmd_t;

  // Master frame states
  typedef enum logic [2:0] {
    // Bus parked with all selects high
    ST_IDLE  = 3'd0,
    // Select low and first bit on mosi before any edge
    ST_SETUP = 3'd1,
    // Sixteen sclk periods of data
    ST_SHIFT = 3'd2,
    // Select still low after the last falling edge
    ST_HOLD  = 3'd3,
    // Select high gap, then completion
    ST_DONE  = 3'd4
  } spi_state_t;

endpackage

// File: spi_master.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_master (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  logic [$clog2(`SPI_NUM_SLAVES)-1:0] slave_sel,
  input  spi_pkg::spi_cmd_t                  cmd,
  input  logic [$clog2(`SPI_NUM_REGS)-1:0]   addr,
  input  logic [`SPI_DATA_W-1:0]             wdata,
  output logic                               busy,
  output logic                               done,
  output logic [`SPI_DATA_W-1:0]             rdata,
  output logic                               sclk,
  output logic [`SPI_NUM_SLAVES-1:0]         ss,
  output logic                               mosi,
  input  logic                               miso
);
  import spi_pkg::*;

  localparam int NS      = `SPI_NUM_SLAVES;
  localparam int DW      = `SPI_DATA_W;
  localparam int AW      = $clog2(`SPI_NUM_REGS);
  localparam int FRAME_W = 2 * DW;
  localparam int DIV_W   = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
  localparam int HALF_W  = $clog2(2 * FRAME_W);

  // Last half-period of the shift phase
  localparam logic [HALF_W-1:0] LAST_HALF = HALF_W'(2 * FRAME_W - 1);
  // First half-period whose rising edge carries a data bit
  localparam logic [HALF_W-1:0] RX_FIRST  = HALF_W'(FRAME_W);
  // Select high gap in half-periods
  localparam logic [HALF_W-1:0] GAP_HALF  = HALF_W'(2);
  localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(`SPI_CLK_DIV - 1);

  spi_state_t          state;
  logic [DIV_W-1:0]    div_cnt;
  logic [HALF_W-1:0]   half_cnt;
  logic                tick;
  logic [FRAME_W-1:0]  tx_shift;
  logic [DW-1:0]       rx_shift;
  logic [NS-1:0]       ss_sel;

  // End of a half-period
  assign tick = (div_cnt == DIV_LAST);

  // One low select for the addressed slave
  assign ss_sel = ~(NS'(1) << slave_sel);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      div_cnt  <= '0;
      half_cnt <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
      rdata    <= '0;
      sclk     <= 1'b0;
      ss       <= '1;
      mosi     <= 1'b0;
    end else begin
      done    <= 1'b0;
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      case (state)
        ST_IDLE: begin
          div_cnt  <= '0;
          half_cnt <= '0;
          // Requests while busy never reach this branch
          if (start) begin
            state    <= ST_SETUP;
            busy     <= 1'b1;
            ss       <= ss_sel;
            // Command byte then write data, MSB first
            tx_shift <= {cmd, {(DW - 1 - AW){1'b0}}, addr, wdata};
            mosi     <= cmd;
          end
        end
        ST_SETUP: begin
          if (tick) begin
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (tick) begin
            sclk     <= ~sclk;
            half_cnt <= half_cnt + 1'b1;
            if (!half_cnt[0]) begin
              // Rising edge, sample miso in the second byte only
              if (half_cnt >= RX_FIRST) begin
                rx_shift <= {rx_shift[DW-2:0], miso};
              end
            end else begin
              // Falling edge, next bit onto mosi
              tx_shift <= {tx_shift[FRAME_W-2:0], 1'b0};
              mosi     <= tx_shift[FRAME_W-2];
            end
            if (half_cnt == LAST_HALF) begin
              state    <= ST_HOLD;
              half_cnt <= '0;
            end
          end
        end
        ST_HOLD: begin
          if (tick) begin
            state <= ST_DONE;
            ss    <= '1;
            mosi  <= 1'b0;
          end
        end
        ST_DONE: begin
          // Gap lets every slave see its select rise
          if (half_cnt == GAP_HALF) begin
            state <= ST_IDLE;
            busy  <= 1'b0;
            done  <= 1'b1;
            rdata <= rx_shift;
          end else if (tick) begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
          busy  <= 1'b0;
          ss    <= '1;
          sclk  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: spi_slave.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_slave #(
  parameter logic [`SPI_DATA_W-1:0] slave_id = '0
) (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  output logic miso
);
  import spi_pkg::*;

  localparam int DW    = `SPI_DATA_W;
  localparam int AW    = $clog2(`SPI_NUM_REGS);
  localparam int CNT_W = $clog2(2 * DW + 1);

  localparam logic [AW-1:0]    ID_ADDR    = AW'(`SPI_NUM_REGS - 1);
  localparam logic [CNT_W-1:0] CMD_LAST   = CNT_W'(DW - 1);
  localparam logic [CNT_W-1:0] DATA_FIRST = CNT_W'(DW);
  localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(2 * DW - 1);

  logic             sclk_q;
  logic             sclk_qq;
  logic             sclk_rise;
  logic             sclk_fall;
  logic [CNT_W-1:0] bit_cnt;
  logic [DW-1:0]    rx_shift;
  logic [DW-1:0]    rx_next;
  logic [DW-1:0]    tx_shift;
  logic [DW-1:0]    rd_val;
  spi_cmd_t         cmd_op;
  logic [AW-1:0]    cmd_addr;
  // Read/write registers below the identity address
  logic [DW-1:0]    regs [`SPI_NUM_REGS-1];

  // Oversampled sclk edges
  assign sclk_rise = sclk_q & ~sclk_qq;
  assign sclk_fall = ~sclk_q & sclk_qq;

  // Byte including the bit sampled on this edge
  assign rx_next = {rx_shift[DW-2:0], mosi};

  // MSB of the shift register is on the wire even before the first edge
  assign miso = tx_shift[DW-1];

  // Read data for the address in the byte just completed
  always_comb begin
    if (rx_next[AW-1:0] == ID_ADDR) begin
      rd_val = slave_id;
    end else begin
      rd_val = regs[rx_next[AW-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_q  <= 1'b0;
      sclk_qq <= 1'b0;
    end else begin
      sclk_q  <= sclk;
      sclk_qq <= sclk_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      cmd_op   <= CMD_WRITE;
      cmd_addr <= '0;
      tx_shift <= '0;
      for (int i = 0; i < `SPI_NUM_REGS - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (ss_n) begin
      // Deselected, a partial frame is dropped here
      bit_cnt <= '0;
    end else begin
      if (sclk_rise) begin
        rx_shift <= rx_next;
        bit_cnt  <= bit_cnt + 1'b1;
        // Command byte complete
        if (bit_cnt == CMD_LAST) begin
          cmd_op   <= spi_cmd_t'(rx_next[DW-1]);
          cmd_addr <= rx_next[AW-1:0];
          if (spi_cmd_t'(rx_next[DW-1]) == CMD_READ) begin
            tx_shift <= rd_val;
          end
        end
        // Data byte complete, identity stays read-only
        if (bit_cnt == FRAME_LAST && cmd_op == CMD_WRITE && cmd_addr != ID_ADDR) begin
          regs[cmd_addr] <= rx_next;
        end
      end
      // Freshly loaded read data keeps its MSB for the first data bit
      if (sclk_fall && bit_cnt != DATA_FIRST) begin
        tx_shift <= {tx_shift[DW-2:0], 1'b0};
      end
    end
  end

endmodule

// File: spi_slave_array.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_slave_array (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       sclk,
  input  logic [`SPI_NUM_SLAVES-1:0] ss,
  input  logic                       mosi,
  output logic                       miso
);
  localparam int NS = `SPI_NUM_SLAVES;
  localparam int DW = `SPI_DATA_W;

  logic [NS-1:0] slave_miso;

  // Shared sclk and mosi, one select per slave
  for (genvar i = 0; i < NS; i++) begin : g_slave
    spi_slave #(
      .slave_id (DW'(i))
    ) slave_inst (
      .clk  (clk),
      .rst  (rst),
      .sclk (sclk),
      .ss_n (ss[i]),
      .mosi (mosi),
      .miso (slave_miso[i])
    );
  end

  // Lowest selected index wins
  // Scanned downward so the last hit is the lowest
  always_comb begin
    miso = 1'b0;
    for (int j = NS - 1; j >= 0; j--) begin
      if (!ss[j]) begin
        miso = slave_miso[j];
      end
    end
  end

endmodule

// File: spi_subsystem.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_subsystem (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  logic [$clog2(`SPI_NUM_SLAVES)-1:0] slave_sel,
  input  spi_pkg::spi_cmd_t                  cmd,
  input  logic [$clog2(`SPI_NUM_REGS)-1:0]   addr,
  input  logic [`SPI_DATA_W-1:0]             wdata,
  output logic                               busy,
  output logic                               done,
  output logic [`SPI_DATA_W-1:0]             rdata,
  output logic                               sclk,
  output logic [`SPI_NUM_SLAVES-1:0]         ss,
  output logic                               mosi
);
  // Return path from the selected slave
  logic miso;

  spi_master master_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .slave_sel (slave_sel),
    .cmd       (cmd),
    .addr      (addr),
    .wdata     (wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .sclk      (sclk),
    .ss        (ss),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_slave_array slave_array_inst (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .ss   (ss),
    .mosi (mosi),
    .miso (miso)
  );

endmodule

// File: spi_subsystem_assert.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_subsystem_assert (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       done,
  input  logic                       sclk,
  input  logic [`SPI_NUM_SLAVES-1:0] ss,
  input  spi_pkg::spi_state_t        state,
  output logic                       failed
);
  import spi_pkg::*;

  // Start cycle to done cycle
  localparam int LATENCY = 2 + 36 * `SPI_CLK_DIV;

  // One sticky flag per property
  logic select_err  = 1'b0;
  logic idle_err    = 1'b0;
  logic pulse_err   = 1'b0;
  logic latency_err = 1'b0;

  assign failed = select_err | idle_err | pulse_err | latency_err;

  // Never two slaves driving the shared miso path
  a_one_select: assert property (@(posedge clk) disable iff (rst)
    $countones(~ss) <= 1)
    else begin
      select_err <= 1'b1;
      $error("more than one slave select low, ss=%h", ss);
    end

  // Parked bus between frames
  a_idle_bus: assert property (@(posedge clk) disable iff (rst)
    state == ST_IDLE |-> (ss == '1) && !sclk)
    else begin
      idle_err <= 1'b1;
      $error("bus not parked in idle, ss=%h sclk=%h", ss, sclk);
    end

  // done lasts exactly one cycle
  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else begin
      pulse_err <= 1'b1;
      $error("done held high for more than one cycle");
    end

  // Accepted start always completes after the fixed frame length
  a_done_after_start: assert property (@(posedge clk) disable iff (rst)
    start && state == ST_IDLE |-> ##LATENCY done)
    else begin
      latency_err <= 1'b1;
      $error("done missing %0d cycles after an accepted start", LATENCY);
    end

  // And never earlier or without a start
  a_start_before_done: assert property (@(posedge clk) disable iff (rst)
    done |-> $past(start && state == ST_IDLE, LATENCY))
    else begin
      latency_err <= 1'b1;
      $error("done without an accepted start %0d cycles before", LATENCY);
    end

endmodule

// Checker sits inside every master instance
bind spi_master spi_subsystem_assert assert_inst (
  .clk    (clk),
  .rst    (rst),
  .start  (start),
  .done   (done),
  .sclk   (sclk),
  .ss     (ss),
  .state  (state),
  .failed ()
);

// File: tb_spi_subsystem.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module tb_spi_subsystem;
  import spi_pkg::*;

  localparam int NS           = `SPI_NUM_SLAVES;
  localparam int DW           = `SPI_DATA_W;
  localparam int SEL_W        = $clog2(`SPI_NUM_SLAVES);
  localparam int ADDR_W       = $clog2(`SPI_NUM_REGS);
  localparam int RW_REGS      = `SPI_NUM_REGS - 1;
  localparam int FRAME_CYCLES = 2 + 36 * `SPI_CLK_DIV;
  localparam int NUM_PAIRS    = 16;
  // Pairs, per-address sweeps, identity checks, dropped start with its settle wait
  localparam int NUM_FRAMES   = 2 * NUM_PAIRS + RW_REGS * (2 * NS + 1) + 3 * NS + 3;
  localparam int WATCHDOG_NS  = (NUM_FRAMES + 4) * FRAME_CYCLES * 10;

  logic              clk;
  logic              rst;
  logic              start;
  logic [SEL_W-1:0]  slave_sel;
  spi_cmd_t          cmd;
  logic [ADDR_W-1:0] addr;
  logic [DW-1:0]     wdata;
  logic              busy;
  logic              done;
  logic [DW-1:0]     rdata;
  logic              sclk;
  logic [NS-1:0]     ss;
  logic              mosi;

  // Expected register contents, identity excluded
  logic [DW-1:0] model [NS][RW_REGS];
  int            done_cnt = 0;
  int            frames_issued = 0;

  spi_subsystem spi_subsystem_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .slave_sel (slave_sel),
    .cmd       (cmd),
    .addr      (addr),
    .wdata     (wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .sclk      (sclk),
    .ss        (ss),
    .mosi      (mosi)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Identity address returns the slave index
  function automatic logic [DW-1:0] expected_value(input int sel, input int a);
    if (a == RW_REGS) begin
      return DW'(sel);
    end else begin
      return model[sel][a];
    end
  endfunction

  // Every done pulse seen on the host side
  always @(negedge clk) begin
    if (!rst && done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  // Bound checker flags
  always @(negedge clk) begin
    if (!rst) begin
      assert (!spi_subsystem_inst.master_inst.assert_inst.failed)
        else fail_run("bound bus checker reported a violation");
    end
  end

  task automatic issue_start(input int sel, input spi_cmd_t op, input int a,
                             input logic [DW-1:0] data);
    @(posedge clk);
    start     <= 1'b1;
    slave_sel <= SEL_W'(sel);
    cmd       <= op;
    addr      <= ADDR_W'(a);
    wdata     <= data;
    @(posedge clk);
    start <= 1'b0;
    frames_issued++;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!done && waited < 2 * FRAME_CYCLES);
    assert (done) else fail_run("no done pulse within the frame timeout");
  endtask

  task automatic run_frame(input int sel, input spi_cmd_t op, input int a,
                           input logic [DW-1:0] data);
    logic [DW-1:0] expected;
    expected = expected_value(sel, a);
    issue_start(sel, op, a, data);
    wait_done();
    if (op == CMD_READ) begin
      assert (rdata == expected)
        else fail_run($sformatf("ERR rdata got %h expected %h (slave %0d addr %0d)",
                                rdata, expected, sel, a));
    end else if (a < RW_REGS) begin
      model[sel][a] = data;
    end
  endtask

  // Start pulsed mid-frame must vanish
  task automatic check_dropped_start();
    logic [DW-1:0] stray;
    stray = ~model[6][2];
    issue_start(2, CMD_WRITE, 1, 8'h5a);
    repeat (20) @(negedge clk);
    assert (busy) else fail_run("busy was low in the middle of a frame");
    @(posedge clk);
    start     <= 1'b1;
    slave_sel <= SEL_W'(6);
    cmd       <= CMD_WRITE;
    addr      <= ADDR_W'(2);
    wdata     <= stray;
    @(posedge clk);
    start <= 1'b0;
    wait_done();
    model[2][1] = 8'h5a;
    // Room for a second done had the stray start been taken
    repeat (FRAME_CYCLES + 4) @(negedge clk);
    assert (done_cnt == frames_issued && !busy)
      else fail_run($sformatf("ERR done_cnt got %h expected %h", done_cnt, frames_issued));
    run_frame(6, CMD_READ, 2, '0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the test sequence finished");
  end

  initial begin
    int sel;
    int a;
    int target;
    logic [DW-1:0] val;
    void'($urandom(32'h1e9b_d2ff));
    rst       = 1'b1;
    start     = 1'b0;
    slave_sel = '0;
    cmd       = CMD_WRITE;
    addr      = '0;
    wdata     = '0;
    for (int s = 0; s < NS; s++) begin
      for (int r = 0; r < RW_REGS; r++) begin
        model[s][r] = '0;
      end
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (ss == '1 && !sclk && !mosi && !busy && !done && rdata == '0)
      else fail_run($sformatf(
        "ERR ss got %h sclk %h mosi %h busy %h done %h rdata %h expected ss %h rest 0",
        ss, sclk, mosi, busy, done, rdata, {NS{1'b1}}));

    // Random write then read back
    for (int i = 0; i < NUM_PAIRS; i++) begin
      sel = int'($urandom_range(NS - 1, 0));
      a   = int'($urandom_range(RW_REGS - 1, 0));
      val = DW'($urandom());
      run_frame(sel, CMD_WRITE, a, val);
      run_frame(sel, CMD_READ, a, '0);
    end

    // Fill one address everywhere, hit one slave, read all back
    for (int r = 0; r < RW_REGS; r++) begin
      for (int s = 0; s < NS; s++) begin
        run_frame(s, CMD_WRITE, r, DW'($urandom()));
      end
      target = int'($urandom_range(NS - 1, 0));
      run_frame(target, CMD_WRITE, r, ~model[target][r]);
      for (int s = 0; s < NS; s++) begin
        run_frame(s, CMD_READ, r, '0);
      end
    end

    // Identity register is read-only
    for (int s = 0; s < NS; s++) begin
      run_frame(s, CMD_READ, RW_REGS, '0);
      run_frame(s, CMD_WRITE, RW_REGS, DW'($urandom()));
      run_frame(s, CMD_READ, RW_REGS, '0);
    end

    check_dropped_start();

    @(negedge clk);
    if (done_cnt == frames_issued) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run($sformatf("ERR done_cnt got %h expected %h", done_cnt, frames_issued));
    end
  end

endmodule

// File: files.f
+incdir+.
spi_pkg.sv
spi_master.sv
spi_slave.sv
spi_slave_array.sv
spi_subsystem.sv
spi_subsystem_assert.sv
tb_spi_subsystem.sv

// File: Makefile
TOP := tb_spi_subsystem
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f *.sv spi_params.svh
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
